//--- design/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       full,
    output logic       empty
);

    logic [7:0]                 mem [com_pkg::fifo_depth];
    logic [com_pkg::fifo_aw-1:0] wr_ptr;
    logic [com_pkg::fifo_aw-1:0] rd_ptr;
    logic [com_pkg::fifo_aw:0]   count;
    logic                       wr_en;
    logic                       rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign full     = (count == com_pkg::fifo_depth);
    assign empty    = (count == 0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/com_cs.sv
`timescale 1ns/1ps

module com_cs (
    input  logic       clk,
    input  logic       rst,

    input  logic       fs_send,
    output logic       fd_send,
    output logic       fs_read,
    input  logic       fd_read,

    output logic       fs_com_send,
    input  logic       fd_com_send,
    input  logic       fs_com_read,
    output logic       fd_com_read,

    output logic [3:0] com_tx_btype,
    input  logic [3:0] com_rx_btype,

    output logic [3:0] data_idx,
    output logic [3:0] com_btype
);

    logic [com_pkg::st_w-1:0] state;
    logic [com_pkg::st_w-1:0] next_state;
    logic go_read;
    logic go_send;

    // peer traffic takes priority over a host send.
    assign go_read = (state == com_pkg::s_main_wait) && fs_com_read;
    assign go_send = (state == com_pkg::s_main_wait) && !fs_com_read && fs_send;

    assign fd_send     = (state == com_pkg::s_send_done);
    assign fs_read     = (state == com_pkg::s_read_idle);
    assign fs_com_send = (state == com_pkg::s_read_work) || (state == com_pkg::s_send_idle);
    assign fd_com_read = (state == com_pkg::s_read_wait) || (state == com_pkg::s_send_work);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= com_pkg::s_main_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            com_pkg::s_main_idle: next_state = com_pkg::s_main_wait;
            com_pkg::s_main_wait: begin
                if (go_read) begin
                    next_state = com_pkg::s_read_idle;
                end else if (go_send) begin
                    next_state = com_pkg::s_send_idle;
                end
            end
            com_pkg::s_read_idle: begin
                if (fd_read) begin
                    next_state = com_pkg::s_read_wait;
                end
            end
            com_pkg::s_read_wait: begin
                if (!fs_com_read) begin
                    next_state = com_pkg::s_read_work;
                end
            end
            com_pkg::s_read_work: begin
                if (fd_com_send) begin
                    next_state = com_pkg::s_read_done;
                end
            end
            com_pkg::s_read_done: next_state = com_pkg::s_main_idle;
            com_pkg::s_send_idle: begin
                if (fd_com_send) begin
                    next_state = com_pkg::s_send_wait;
                end
            end
            com_pkg::s_send_wait: begin
                if (fs_com_read) begin
                    next_state = com_pkg::s_send_work;
                end
            end
            com_pkg::s_send_work: begin
                if (!fs_com_read) begin
                    next_state = com_pkg::s_send_done;
                end
            end
            com_pkg::s_send_done: begin
                if (!fs_send) begin
                    next_state = com_pkg::s_main_idle;
                end
            end
            default: next_state = com_pkg::s_main_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_idx <= 4'h0;
        end else if (go_send) begin
            data_idx <= (data_idx == com_pkg::data_idx_max) ? 4'h0 : data_idx + 4'h1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            com_tx_btype <= com_pkg::btype_init;
        end else if (state == com_pkg::s_main_idle) begin
            com_tx_btype <= com_pkg::btype_init;
        end else if (go_read) begin
            com_tx_btype <= com_pkg::btype_info;
        end else if (go_send) begin
            com_tx_btype <= com_pkg::btype_data;
        end
    end

    // received type is held for the whole read exchange.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            com_btype <= com_pkg::btype_init;
        end else if (state == com_pkg::s_main_idle) begin
            com_btype <= com_pkg::btype_init;
        end else if (go_read) begin
            com_btype <= com_rx_btype;
        end
    end

endmodule

//--- design/com_link_top.sv
`timescale 1ns/1ps

module com_link_top (
    input  logic        clk,
    input  logic        rst,

    input  logic        fs_send,
    input  logic [31:0] tx_word,
    output logic        fd_send,
    output logic        fs_read,
    input  logic        fd_read,
    output logic [3:0]  com_btype,
    output logic [3:0]  data_idx,

    input  logic        fs_com_read,
    input  logic [3:0]  com_rx_btype,
    output logic        fd_com_read,
    output logic [7:0]  tx_byte,
    output logic        tx_strobe,
    output logic        tx_last,
    input  logic        tx_ready
);

    logic       fs_com_send;
    logic       fd_com_send;
    logic [3:0] com_tx_btype;
    logic       push;
    logic [7:0] push_data;
    logic       full;
    logic       pop;
    logic [7:0] pop_data;
    logic       empty;

    com_cs i_com_cs (
        .clk          (clk),
        .rst          (rst),
        .fs_send      (fs_send),
        .fd_send      (fd_send),
        .fs_read      (fs_read),
        .fd_read      (fd_read),
        .fs_com_send  (fs_com_send),
        .fd_com_send  (fd_com_send),
        .fs_com_read  (fs_com_read),
        .fd_com_read  (fd_com_read),
        .com_tx_btype (com_tx_btype),
        .com_rx_btype (com_rx_btype),
        .data_idx     (data_idx),
        .com_btype    (com_btype)
    );

    frame_builder i_frame_builder (
        .clk          (clk),
        .rst          (rst),
        .fs_com_send  (fs_com_send),
        .com_tx_btype (com_tx_btype),
        .data_idx     (data_idx),
        .com_btype    (com_btype),
        .tx_word      (tx_word),
        .full         (full),
        .push         (push),
        .push_data    (push_data)
    );

    byte_fifo i_byte_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    frame_serializer i_frame_serializer (
        .clk         (clk),
        .rst         (rst),
        .empty       (empty),
        .pop_data    (pop_data),
        .tx_ready    (tx_ready),
        .pop         (pop),
        .tx_byte     (tx_byte),
        .tx_strobe   (tx_strobe),
        .tx_last     (tx_last),
        .fd_com_send (fd_com_send)
    );

endmodule

//--- design/com_pkg.sv
package com_pkg;

    // block types carried in the upper half of the header byte.
    localparam logic [3:0] btype_init = 4'h0;
    localparam logic [3:0] btype_info = 4'h1;
    localparam logic [3:0] btype_data = 4'hE;

    // data index runs 0..5 and wraps.
    localparam logic [3:0] data_idx_max = 4'h5;

    localparam int payload_bytes = 4;

    localparam int fifo_depth = 8;
    localparam int fifo_aw = 3;

    // one-hot session states.
    localparam int st_w = 10;
    localparam logic [st_w-1:0] s_main_idle = 10'h001;
    localparam logic [st_w-1:0] s_main_wait = 10'h002;
    localparam logic [st_w-1:0] s_read_idle = 10'h004;
    localparam logic [st_w-1:0] s_read_wait = 10'h008;
    localparam logic [st_w-1:0] s_read_work = 10'h010;
    localparam logic [st_w-1:0] s_read_done = 10'h020;
    localparam logic [st_w-1:0] s_send_idle = 10'h040;
    localparam logic [st_w-1:0] s_send_wait = 10'h080;
    localparam logic [st_w-1:0] s_send_work = 10'h100;
    localparam logic [st_w-1:0] s_send_done = 10'h200;

    // header byte: data frames carry the index, info frames echo the peer's type.
    typedef union packed {
        struct packed {
            logic [3:0] btype;
            logic [3:0] idx;
        } data;
        struct packed {
            logic [3:0] btype;
            logic [3:0] echo;
        } info;
    } frame_hdr_u;

endpackage

//--- design/frame_builder.sv
`timescale 1ns/1ps

module frame_builder (
    input  logic        clk,
    input  logic        rst,
    input  logic        fs_com_send,
    input  logic [3:0]  com_tx_btype,
    input  logic [3:0]  data_idx,
    input  logic [3:0]  com_btype,
    input  logic [31:0] tx_word,
    input  logic        full,
    output logic        push,
    output logic [7:0]  push_data
);

    logic                armed;
    logic                busy;
    logic                start;
    logic [2:0]          cnt;
    logic [2:0]          last_cnt;
    logic                last_byte;
    logic [7:0]          csum;
    logic [31:0]         word_r;
    com_pkg::frame_hdr_u hdr_next;
    com_pkg::frame_hdr_u hdr_r;

    assign start = fs_com_send && armed && !busy;

    always_comb begin
        hdr_next = '0;
        if (com_tx_btype == com_pkg::btype_data) begin
            hdr_next.data.btype = com_tx_btype;
            hdr_next.data.idx   = data_idx;
        end else begin
            hdr_next.info.btype = com_tx_btype;
            hdr_next.info.echo  = com_btype;
        end
    end

    // header, payload, then checksum.
    assign last_cnt  = (hdr_r.data.btype == com_pkg::btype_data) ?
                       3'(com_pkg::payload_bytes + 1) : 3'd1;
    assign last_byte = (cnt == last_cnt);
    assign push      = busy && !full;

    always_comb begin
        if (cnt == 3'd0) begin
            push_data = hdr_r;
        end else if (last_byte) begin
            push_data = csum;
        end else begin
            push_data = word_r[31:24];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed <= 1'b1;
            busy  <= 1'b0;
            cnt   <= 3'd0;
        end else begin
            if (start) begin
                armed <= 1'b0;
            end else if (!fs_com_send) begin
                armed <= 1'b1;
            end
            if (start) begin
                busy <= 1'b1;
                cnt  <= 3'd0;
            end else if (push) begin
                busy <= !last_byte;
                cnt  <= last_byte ? 3'd0 : cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            hdr_r  <= hdr_next;
            word_r <= tx_word;
            csum   <= 8'h00;
        end else if (push) begin
            csum <= csum ^ push_data;
            if (cnt != 3'd0) begin
                word_r <= {word_r[23:0], 8'h00};
            end
        end
    end

endmodule

//--- design/frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer (
    input  logic       clk,
    input  logic       rst,
    input  logic       empty,
    input  logic [7:0] pop_data,
    input  logic       tx_ready,
    output logic       pop,
    output logic [7:0] tx_byte,
    output logic       tx_strobe,
    output logic       tx_last,
    output logic       fd_com_send
);

    com_pkg::frame_hdr_u head;
    logic [2:0]          rem;
    logic [2:0]          rem_hdr;

    // bytes still to come after the one being popped, zero between frames.
    assign head    = pop_data;
    assign rem_hdr = (head.data.btype == com_pkg::btype_data) ?
                     3'(com_pkg::payload_bytes + 1) : 3'd1;

    assign pop = tx_ready && !empty;

    // the FIFO head register drives the link, so a strobe never outlives tx_ready.
    assign tx_byte   = pop_data;
    assign tx_strobe = pop;
    assign tx_last   = pop && (rem == 3'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem         <= 3'd0;
            fd_com_send <= 1'b0;
        end else begin
            fd_com_send <= tx_last;
            if (pop) begin
                rem <= (rem == 3'd0) ? rem_hdr : rem - 3'd1;
            end
        end
    end

endmodule

//--- files.f
design/com_pkg.sv
design/com_cs.sv
design/frame_builder.sv
design/byte_fifo.sv
design/frame_serializer.sv
design/com_link_top.sv
sim/tb_clock.sv
sim/com_link_assertions.sv
sim/com_link_tb.sv

//--- sim/com_link_assertions.sv
`timescale 1ns/1ps

module com_link_assertions (
    input logic clk,
    input logic rst,
    input logic tx_strobe,
    input logic tx_ready,
    input logic tx_last,
    input logic fd_com_send,
    input logic push,
    input logic full
);

    int fails = 0;

    // the link only sees a byte when the peer is ready.
    strobe_needs_ready: assert property (@(posedge clk) disable iff (rst)
        tx_strobe |-> tx_ready)
        else begin
            $error("tx_strobe high while tx_ready is low");
            fails++;
        end

    last_then_done: assert property (@(posedge clk) disable iff (rst)
        (tx_strobe && tx_last) |=> fd_com_send)
        else begin
            $error("fd_com_send missing after the last byte of a frame");
            fails++;
        end

    done_after_last: assert property (@(posedge clk) disable iff (rst)
        fd_com_send |-> $past(tx_strobe && tx_last))
        else begin
            $error("fd_com_send without a preceding last byte");
            fails++;
        end

    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else begin
            $error("push while the FIFO is full");
            fails++;
        end

endmodule

bind com_link_top com_link_assertions i_com_link_assertions (
    .clk         (clk),
    .rst         (rst),
    .tx_strobe   (tx_strobe),
    .tx_ready    (tx_ready),
    .tx_last     (tx_last),
    .fd_com_send (fd_com_send),
    .push        (push),
    .full        (full)
);

//--- sim/com_link_tb.sv
`timescale 1ns/1ps

module com_link_tb;

    localparam int n_ops_max = 16;
    localparam int limit = 200;
    localparam int op_send = 0;
    localparam int op_read = 1;
    localparam int op_both = 2;
    localparam int sel_fd_send = 0;
    localparam int sel_fs_read = 1;
    localparam int sel_fd_com_read = 2;

    logic        clk;
    logic        rst;
    logic        fs_send;
    logic [31:0] tx_word;
    logic        fd_send;
    logic        fs_read;
    logic        fd_read;
    logic [3:0]  com_btype;
    logic [3:0]  data_idx;
    logic        fs_com_read;
    logic [3:0]  com_rx_btype;
    logic        fd_com_read;
    logic [7:0]  tx_byte;
    logic        tx_strobe;
    logic        tx_last;
    logic        tx_ready;

    // stimulus table, one entry per operation.
    int          op_kind [n_ops_max];
    logic [31:0] op_word [n_ops_max];
    logic [3:0]  op_rx [n_ops_max];
    logic        op_rand [n_ops_max];
    int          n_ops;

    logic        ready_bits [256];
    logic [7:0]  ready_ptr;
    logic        ready_random;

    logic [7:0]  obs_bytes [$];
    logic        obs_last [$];
    logic [7:0]  exp_bytes [$];
    logic        exp_last [$];

    int          frames_done;
    int          strobes;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errs0;
    logic [3:0]  model_idx;
    logic        timed_out;

    tb_clock i_tb_clock (
        .clk (clk)
    );

    com_link_top i_com_link_top (
        .clk          (clk),
        .rst          (rst),
        .fs_send      (fs_send),
        .tx_word      (tx_word),
        .fd_send      (fd_send),
        .fs_read      (fs_read),
        .fd_read      (fd_read),
        .com_btype    (com_btype),
        .data_idx     (data_idx),
        .fs_com_read  (fs_com_read),
        .com_rx_btype (com_rx_btype),
        .fd_com_read  (fd_com_read),
        .tx_byte      (tx_byte),
        .tx_strobe    (tx_strobe),
        .tx_last      (tx_last),
        .tx_ready     (tx_ready)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic sig_val(input int sel);
        case (sel)
            sel_fd_send:     return fd_send;
            sel_fs_read:     return fs_read;
            sel_fd_com_read: return fd_com_read;
            default:         return 1'bx;
        endcase
    endfunction

    task automatic wait_for(input int sel, input logic val, input string what);
        int n;
        n = 0;
        while (sig_val(sel) !== val && n < limit && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (sig_val(sel) !== val && !timed_out) begin
            $display("Timeout: %s did not reach %0b within %0d cycles", what, val, limit);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic wait_frames(input int target, input string what);
        int n;
        n = 0;
        while (frames_done < target && n < limit && !timed_out) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (frames_done < target && !timed_out) begin
            $display("Timeout: no %s on the link within %0d cycles", what, limit);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic add_op(input int kind, input logic [31:0] word, input logic [3:0] rx,
                          input logic rnd);
        op_kind[n_ops] = kind;
        op_word[n_ops] = word;
        op_rx[n_ops]   = rx;
        op_rand[n_ops] = rnd;
        n_ops++;
    endtask

    // reference frame: header, payload msb first, xor of all earlier bytes.
    task automatic expect_frame(input logic [7:0] hdr, input logic [31:0] word, input int n_pay);
        logic [7:0] csum;
        logic [7:0] b;
        csum = hdr;
        exp_bytes.push_back(hdr);
        exp_last.push_back(1'b0);
        for (int i = 0; i < n_pay; i++) begin
            b = word[31 - 8*i -: 8];
            csum = csum ^ b;
            exp_bytes.push_back(b);
            exp_last.push_back(1'b0);
        end
        exp_bytes.push_back(csum);
        exp_last.push_back(1'b1);
    endtask

    task automatic expect_data(input logic [31:0] word);
        com_pkg::frame_hdr_u hdr;
        model_idx = (model_idx + 4'h1) % (com_pkg::data_idx_max + 4'h1);
        hdr.data.btype = com_pkg::btype_data;
        hdr.data.idx   = model_idx;
        expect_frame(hdr, word, com_pkg::payload_bytes);
    endtask

    task automatic expect_info(input logic [3:0] rx);
        com_pkg::frame_hdr_u hdr;
        hdr.info.btype = com_pkg::btype_info;
        hdr.info.echo  = rx;
        expect_frame(hdr, 32'h0, 0);
    endtask

    task automatic host_read(input logic [3:0] rx, input int strobes0);
        wait_for(sel_fs_read, 1'b1, "fs_read");
        check("com_btype", com_btype, rx);
        fd_read = 1'b1;
        wait_for(sel_fd_com_read, 1'b1, "fd_com_read");
        fd_read = 1'b0;
        // the info frame waits for the peer to let go.
        repeat (4) begin
            @(posedge clk);
            #1;
            check("fd_com_read", fd_com_read, 1'b1);
            check("fs_read", fs_read, 1'b0);
        end
        check("strobes before release", strobes, strobes0);
        fs_com_read = 1'b0;
    endtask

    task automatic peer_ack();
        fs_com_read = 1'b1;
        wait_for(sel_fd_com_read, 1'b1, "fd_com_read");
        fs_com_read = 1'b0;
        wait_for(sel_fd_com_read, 1'b0, "fd_com_read release");
    endtask

    task automatic finish_send();
        check("fd_send", fd_send, 1'b0);
        peer_ack();
        wait_for(sel_fd_send, 1'b1, "fd_send");
        check("data_idx", data_idx, model_idx);
        repeat (3) begin
            @(posedge clk);
            #1;
            check("fd_send", fd_send, 1'b1);
        end
        fs_send = 1'b0;
        wait_for(sel_fd_send, 1'b0, "fd_send release");
    endtask

    task automatic run_send(input logic [31:0] word);
        int frames0;
        frames0 = frames_done;
        fs_send = 1'b1;
        tx_word = word;
        expect_data(word);
        wait_frames(frames0 + 1, "data frame");
        finish_send();
    endtask

    task automatic run_read(input logic [3:0] rx);
        int frames0;
        int strobes0;
        frames0 = frames_done;
        strobes0 = strobes;
        fs_com_read  = 1'b1;
        com_rx_btype = rx;
        expect_info(rx);
        host_read(rx, strobes0);
        wait_frames(frames0 + 1, "info frame");
    endtask

    // read wins, so the info frame goes out before the data frame.
    task automatic run_both(input logic [31:0] word, input logic [3:0] rx);
        int frames0;
        int strobes0;
        frames0 = frames_done;
        strobes0 = strobes;
        fs_send      = 1'b1;
        tx_word      = word;
        fs_com_read  = 1'b1;
        com_rx_btype = rx;
        expect_info(rx);
        expect_data(word);
        host_read(rx, strobes0);
        wait_frames(frames0 + 2, "info and data frames");
        finish_send();
    endtask

    task automatic compare_frames();
        int n;
        check("frame byte count", obs_bytes.size(), exp_bytes.size());
        n = (obs_bytes.size() < exp_bytes.size()) ? obs_bytes.size() : exp_bytes.size();
        for (int k = 0; k < n; k++) begin
            check($sformatf("tx_byte[%0d]", k), obs_bytes[k], exp_bytes[k]);
            check($sformatf("tx_last[%0d]", k), obs_last[k], exp_last[k]);
        end
        obs_bytes.delete();
        obs_last.delete();
        exp_bytes.delete();
        exp_last.delete();
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errs_before);
        end
    endtask

    // link monitor, sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst) begin
            check("tx_strobe while tx_ready low", tx_strobe && !tx_ready, 1'b0);
            if (tx_strobe) begin
                obs_bytes.push_back(tx_byte);
                obs_last.push_back(tx_last);
                strobes++;
                if (tx_last) begin
                    frames_done++;
                end
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (ready_random) begin
            tx_ready = ready_bits[ready_ptr];
            ready_ptr = ready_ptr + 8'd1;
        end else begin
            tx_ready = 1'b1;
        end
    end

    initial begin
        void'($urandom(32'h6fea_3aa5));
        for (int k = 0; k < 256; k++) begin
            ready_bits[k] = $urandom % 2;
        end
        rst = 1'b1;
        fs_send = 1'b0;
        tx_word = 32'h0;
        fd_read = 1'b0;
        fs_com_read = 1'b0;
        com_rx_btype = 4'h0;
        tx_ready = 1'b1;
        ready_random = 1'b0;
        ready_ptr = 8'd0;
        frames_done = 0;
        strobes = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        model_idx = 4'h0;
        timed_out = 1'b0;
        n_ops = 0;

        add_op(op_send, 32'h1234_5678, 4'h0, 1'b0);
        add_op(op_send, 32'hdead_beef, 4'h0, 1'b0);
        add_op(op_send, 32'h0000_0000, 4'h0, 1'b0);
        add_op(op_send, 32'hffff_ffff, 4'h0, 1'b0);
        add_op(op_send, 32'ha5c3_0f96, 4'h0, 1'b0);
        add_op(op_send, 32'h0102_0408, 4'h0, 1'b0);
        add_op(op_read, 32'h0, 4'h7, 1'b0);
        add_op(op_send, 32'hcafe_f00d, 4'h0, 1'b1);
        add_op(op_read, 32'h0, 4'ha, 1'b1);
        add_op(op_both, 32'h7e57_1ee7, 4'h3, 1'b1);
        add_op(op_both, 32'h89ab_cdef, 4'he, 1'b0);
        add_op(op_send, 32'h5a5a_a5a5, 4'h0, 1'b1);

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        errs0 = errors;
        check("fd_send", fd_send, 1'b0);
        check("fs_read", fs_read, 1'b0);
        check("fd_com_read", fd_com_read, 1'b0);
        check("tx_strobe", tx_strobe, 1'b0);
        check("tx_last", tx_last, 1'b0);
        check("data_idx", data_idx, 4'h0);
        check("com_btype", com_btype, 4'h0);
        repeat (10) begin
            @(posedge clk);
            #1;
        end
        check("idle strobes", strobes, 0);
        report_test("reset and idle", errs0);

        for (int i = 0; i < n_ops && !timed_out; i++) begin
            ready_random = op_rand[i];
            errs0 = errors;
            case (op_kind[i])
                op_send: run_send(op_word[i]);
                op_read: run_read(op_rx[i]);
                default: run_both(op_word[i], op_rx[i]);
            endcase
            compare_frames();
            case (op_kind[i])
                op_send: report_test(op_rand[i] ? "send, random ready" : "send", errs0);
                op_read: report_test(op_rand[i] ? "peer read, random ready" : "peer read",
                                     errs0);
                default: report_test("send and peer read together", errs0);
            endcase
        end

        if (i_com_link_top.i_com_link_assertions.fails != 0) begin
            $display("%0d assertion failures reported by the link checker",
                     i_com_link_top.i_com_link_assertions.fails);
            errors = errors + i_com_link_top.i_com_link_assertions.fails;
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam time half_period = 5ns;

    initial begin
        clk = 1'b0;
    end

    // 10 ns period.
    always #(half_period) clk = ~clk;

endmodule
